// File: hw/ctr_params.svh
/*
 * Build-time sizes for the counter-block subsystem
 * Counter width is CTR_SLICES * CTR_SLICE_W and must stay 128
 * Host credits must match the dispatcher queue depth
 */
`ifndef CTR_PARAMS_SVH
`define CTR_PARAMS_SVH

// Number of identical counter lanes
`define CTR_LANES 4

// Incrementer works one slice per cycle
`define CTR_SLICE_W 16
`define CTR_SLICES 8

// Host credits after reset, same as queue depth
`define CTR_CMD_CREDITS 2

// Output credits after reset
`define CTR_OUT_CREDITS 4

`endif

// File: hw/ctr_pkg.sv
/*
 * Shared types for the counter lanes, dispatcher, collector and testbench
 * State encodings are sparse, any two valid codes differ in 3 or more bits
 */
`include "ctr_params.svh"

package ctr_pkg;

  ////////////////////
  // Basic vectors
  ////////////////////

  // Full counter block
  typedef logic [`CTR_SLICES*`CTR_SLICE_W-1:0] ctr_value_t;

  // Lane number carried with commands and results
  typedef logic [$clog2(`CTR_LANES)-1:0] lane_idx_t;

  // Slice pointer inside the incrementer
  typedef logic [$clog2(`CTR_SLICES)-1:0] slice_idx_t;

  ////////////////////
  // Enums
  ////////////////////

  // Host opcodes
  typedef enum logic {
    CTR_OP_LOAD = 1'b0,
    CTR_OP_INCR = 1'b1
  } ctr_op_e;

  // Lane FSM, 5-bit sparse
  // Distances: IDLE-INCR 4, IDLE-DONE 3, INCR-DONE 3
  // ERROR sits at 3 or more from every other code
  typedef enum logic [4:0] {
    CTR_IDLE  = 5'b01011,
    CTR_INCR  = 5'b10110,
    CTR_DONE  = 5'b11101,
    CTR_ERROR = 5'b00000
  } ctr_state_e;

  ////////////////////
  // Bus payloads
  ////////////////////

  // Host command, 131 bits
  typedef struct packed {
    lane_idx_t  lane;
    ctr_op_e    op;
    ctr_value_t value;
  } ctr_cmd_t;

  // Lane result, 130 bits
  typedef struct packed {
    lane_idx_t  lane;
    ctr_value_t value;
  } ctr_rsp_t;

endpackage

// File: hw/ctr_dispatch.sv
/*
 * Command queue between the host and the counter lanes
 * Host must only send while it holds a credit; extra pushes into a full queue are lost
 * The queue head blocks until its lane has a credit, keeping commands in order
 */
`include "ctr_params.svh"

module ctr_dispatch (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_valid_i,
  input  ctr_pkg::ctr_cmd_t     cmd_i,
  output logic                  cmd_credit_o,
  input  logic [`CTR_LANES-1:0] lane_credit_i,
  output logic [`CTR_LANES-1:0] lane_cmd_valid_o,
  output ctr_pkg::ctr_cmd_t     lane_cmd_o
);
  import ctr_pkg::*;

  localparam int unsigned Depth = `CTR_CMD_CREDITS;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  // Queue storage and pointers
  ctr_cmd_t              fifo_q [Depth];
  logic [PtrW-1:0]       wr_ptr_q;
  logic [PtrW-1:0]       rd_ptr_q;
  logic [CntW-1:0]       count_q;

  // One credit bit per lane
  logic [`CTR_LANES-1:0] credit_q;

  logic                  push;
  logic                  pop;
  ctr_cmd_t              head;

  ////////////////////
  // Issue
  ////////////////////

  assign head = fifo_q[rd_ptr_q];

  // Head leaves only toward a lane holding a credit
  assign pop  = (count_q != '0) && credit_q[head.lane];

  // Slot frees up in the same cycle as a pop
  assign push = cmd_valid_i && ((count_q != CntW'(Depth)) || pop);

  always_comb begin
    lane_cmd_valid_o = '0;
    if (pop) begin
      lane_cmd_valid_o[head.lane] = 1'b1;
    end
  end

  assign lane_cmd_o   = head;
  // Host credit back on every issue
  assign cmd_credit_o = pop;

  ////////////////////
  // Queue
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      // Net occupancy change
      if (push && !pop) begin
        count_q <= count_q + CntW'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

  // Lane credits, all free after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '1;
    end else begin
      for (int unsigned k = 0; k < `CTR_LANES; k++) begin
        if (lane_credit_i[k]) begin
          credit_q[k] <= 1'b1;
        end else if (lane_cmd_valid_o[k]) begin
          credit_q[k] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: hw/ctr_lane.sv
/*
 * One counter lane with a slice-serial incrementer
 * INCR takes a fixed 9 cycles, LOAD one; the result is held until taken
 * A bad state code or a command while busy locks the lane in CTR_ERROR until reset
 */
`include "ctr_params.svh"

module ctr_lane (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cmd_valid_i,
  input  ctr_pkg::ctr_cmd_t cmd_i,
  output logic              credit_o,
  output logic              rsp_valid_o,
  output ctr_pkg::ctr_rsp_t rsp_o,
  input  logic              rsp_take_i,
  output logic              alert_o
);
  import ctr_pkg::*;

  ctr_state_e                              state_d, state_q;
  slice_idx_t                              idx_d, idx_q;
  logic                                    carry_d, carry_q;
  logic                                    rsp_valid_d, rsp_valid_q;
  logic                                    credit_d, credit_q;

  // Payload registers
  lane_idx_t                               lane_q;
  logic [`CTR_SLICES-1:0][`CTR_SLICE_W-1:0] ctr_q;

  logic [`CTR_SLICE_W:0]                   slice_sum;
  logic                                    accept;
  logic                                    load;
  logic                                    slice_we;

  ////////////////////
  // Slice adder
  ////////////////////

  // Extra MSB catches the carry into the next slice
  assign slice_sum = {1'b0, ctr_q[idx_q]} + {{`CTR_SLICE_W{1'b0}}, carry_q};

  ////////////////////
  // Control FSM
  ////////////////////

  always_comb begin : fsm_comb
    state_d     = state_q;
    idx_d       = idx_q;
    carry_d     = carry_q;
    rsp_valid_d = rsp_valid_q;
    credit_d    = 1'b0;
    accept      = 1'b0;
    load        = 1'b0;
    slice_we    = 1'b0;
    alert_o     = 1'b0;

    unique case (state_q)
      CTR_IDLE: begin
        if (cmd_valid_i) begin
          accept = 1'b1;
          if (cmd_i.op == CTR_OP_LOAD) begin
            load    = 1'b1;
            state_d = CTR_DONE;
          end else begin
            // Start at the low slice, adding one
            idx_d   = '0;
            carry_d = 1'b1;
            state_d = CTR_INCR;
          end
        end
      end

      CTR_INCR: begin
        slice_we = 1'b1;
        idx_d    = idx_q + slice_idx_t'(1);
        carry_d  = slice_sum[`CTR_SLICE_W];
        // Top slice done, carry out is dropped
        if (idx_q == slice_idx_t'(`CTR_SLICES - 1)) begin
          state_d = CTR_DONE;
        end
      end

      CTR_DONE: begin
        // One cycle to raise valid, then wait for the take
        if (!rsp_valid_q) begin
          rsp_valid_d = 1'b1;
        end else if (rsp_take_i) begin
          rsp_valid_d = 1'b0;
          credit_d    = 1'b1;
          state_d     = CTR_IDLE;
        end
      end

      CTR_ERROR: begin
        // Terminal
        alert_o = 1'b1;
      end

      default: begin
        // Corrupted state code
        state_d = CTR_ERROR;
        alert_o = 1'b1;
      end
    endcase

    // Command while busy means the credit protocol broke
    if (cmd_valid_i && (state_q != CTR_IDLE)) begin
      state_d = CTR_ERROR;
    end

    // No result leaves a failed lane
    if (state_d == CTR_ERROR) begin
      rsp_valid_d = 1'b0;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= CTR_IDLE;
      idx_q       <= '0;
      carry_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
      credit_q    <= 1'b0;
    end else begin
      state_q     <= state_d;
      idx_q       <= idx_d;
      carry_q     <= carry_d;
      rsp_valid_q <= rsp_valid_d;
      credit_q    <= credit_d;
    end
  end

  // Counter and lane tag
  always_ff @(posedge clk_i) begin
    if (load) begin
      ctr_q <= cmd_i.value;
    end else if (slice_we) begin
      ctr_q[idx_q] <= slice_sum[`CTR_SLICE_W-1:0];
    end
    if (accept) begin
      lane_q <= cmd_i.lane;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = '{lane: lane_q, value: ctr_value_t'(ctr_q)};
  // Credit one cycle after the take, lane back in IDLE
  assign credit_o    = credit_q;

endmodule

// File: hw/ctr_collect.sv
/*
 * Round-robin drain of lane results to one output port
 * Output is combinational from the lane hold registers
 * A word goes out only while an output credit is held
 */
`include "ctr_params.svh"

module ctr_collect (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [`CTR_LANES-1:0]              rsp_valid_i,
  input  ctr_pkg::ctr_rsp_t [`CTR_LANES-1:0] rsp_i,
  output logic [`CTR_LANES-1:0]              rsp_take_o,
  output logic                               out_valid_o,
  output ctr_pkg::ctr_rsp_t                  out_o,
  input  logic                               out_credit_i
);
  import ctr_pkg::*;

  localparam int unsigned CntW = $clog2(`CTR_OUT_CREDITS + 1);

  // Last lane granted
  lane_idx_t       last_q;
  lane_idx_t       grant_idx;
  logic            found;
  logic            grant;

  // Output credits held
  logic [CntW-1:0] credit_q;

  ////////////////////
  // Arbiter
  ////////////////////

  // Search starts one past the last grant
  always_comb begin : arb_comb
    lane_idx_t cand;

    found     = 1'b0;
    grant_idx = last_q;
    for (int unsigned i = 1; i <= `CTR_LANES; i++) begin
      cand = lane_idx_t'((32'(last_q) + i) % `CTR_LANES);
      if (!found && rsp_valid_i[cand]) begin
        found     = 1'b1;
        grant_idx = cand;
      end
    end
  end

  // Grant only with a credit in hand
  assign grant       = found && (credit_q != '0);
  assign out_valid_o = grant;
  assign out_o       = rsp_i[grant_idx];

  always_comb begin
    rsp_take_o = '0;
    if (grant) begin
      rsp_take_o[grant_idx] = 1'b1;
    end
  end

  ////////////////////
  // State
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CntW'(`CTR_OUT_CREDITS);
      // Lane 0 first after reset
      last_q   <= lane_idx_t'(`CTR_LANES - 1);
    end else begin
      // Grant and return together cancel out
      unique case ({grant, out_credit_i})
        2'b10:   credit_q <= credit_q - CntW'(1);
        2'b01:   credit_q <= credit_q + CntW'(1);
        default: credit_q <= credit_q;
      endcase
      if (grant) begin
        last_q <= grant_idx;
      end
    end
  end

endmodule

// File: hw/ctr_top.sv
/*
 * Counter-block generator top level
 * Host and consumer must follow the credit rules, or a lane raises alert_o
 * alert_o is sticky until reset
 */
`include "ctr_params.svh"

module ctr_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cmd_valid_i,
  input  ctr_pkg::ctr_cmd_t cmd_i,
  output logic              cmd_credit_o,
  output logic              out_valid_o,
  output ctr_pkg::ctr_rsp_t out_o,
  input  logic              out_credit_i,
  output logic              alert_o
);
  import ctr_pkg::*;

  // Dispatcher to lanes
  logic [`CTR_LANES-1:0]    lane_cmd_valid;
  ctr_cmd_t                 lane_cmd;
  logic [`CTR_LANES-1:0]    lane_credit;

  // Lanes to collector
  logic [`CTR_LANES-1:0]    rsp_valid;
  ctr_rsp_t [`CTR_LANES-1:0] rsp;
  logic [`CTR_LANES-1:0]    rsp_take;

  logic [`CTR_LANES-1:0]    lane_alert;

  ctr_dispatch i_ctr_dispatch (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_i            (cmd_i),
    .cmd_credit_o     (cmd_credit_o),
    .lane_credit_i    (lane_credit),
    .lane_cmd_valid_o (lane_cmd_valid),
    .lane_cmd_o       (lane_cmd)
  );

  // Shared command bus, per-lane valid
  for (genvar k = 0; k < `CTR_LANES; k++) begin : g_lane
    ctr_lane i_ctr_lane (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .cmd_valid_i (lane_cmd_valid[k]),
      .cmd_i       (lane_cmd),
      .credit_o    (lane_credit[k]),
      .rsp_valid_o (rsp_valid[k]),
      .rsp_o       (rsp[k]),
      .rsp_take_i  (rsp_take[k]),
      .alert_o     (lane_alert[k])
    );
  end

  ctr_collect i_ctr_collect (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rsp_valid_i  (rsp_valid),
    .rsp_i        (rsp),
    .rsp_take_o   (rsp_take),
    .out_valid_o  (out_valid_o),
    .out_o        (out_o),
    .out_credit_i (out_credit_i)
  );

  // Any failed lane
  assign alert_o = |lane_alert;

endmodule

// File: sim/ctr_asserts.sv
/*
 * Protocol assertions bound into ctr_top
 * The bind lists four lanes by name and must track CTR_LANES
 */
`include "ctr_params.svh"

module ctr_asserts (
  input logic                                               clk_i,
  input logic                                               rst_ni,
  input logic                                               out_valid_i,
  input logic                                               out_credit_i,
  input logic                                               alert_i,
  input logic [`CTR_LANES-1:0]                              lane_cmd_valid_i,
  input logic [`CTR_LANES-1:0][$bits(ctr_pkg::ctr_state_e)-1:0] lane_state_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import ctr_pkg::*;

  // Output credits left, rebuilt from the port pulses alone
  int credits_left;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_left <= `CTR_OUT_CREDITS;
    end else begin
      credits_left <= credits_left + int'(out_credit_i) - int'(out_valid_i);
    end
  end

  // No output word without a credit
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i |-> (credits_left > 0))
    else $error("output issued with no credit");

  // Dispatcher only talks to idle lanes
  for (genvar k = 0; k < `CTR_LANES; k++) begin : g_idle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      lane_cmd_valid_i[k] |-> (lane_state_i[k] == CTR_IDLE))
      else $error("command sent to busy lane %0d", k);
  end

  // Alert is sticky
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_i |=> alert_i)
    else $error("alert dropped before reset");

endmodule

bind ctr_top ctr_asserts i_ctr_asserts (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .out_valid_i      (out_valid_o),
  .out_credit_i     (out_credit_i),
  .alert_i          (alert_o),
  .lane_cmd_valid_i (lane_cmd_valid),
  .lane_state_i     ({g_lane[3].i_ctr_lane.state_q, g_lane[2].i_ctr_lane.state_q,
                      g_lane[1].i_ctr_lane.state_q, g_lane[0].i_ctr_lane.state_q})
);

// File: sim/ctr_tb.sv
/*
 * Table-driven testbench for ctr_top
 * Expected values in the table are fixed constants, one row per command
 * Consumer returns credits after 1 to 4 cycles and stalls for one stretch
 */
`include "ctr_params.svh"

module ctr_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ctr_pkg::*;

  localparam int unsigned NumTests = 14;

  logic     clk_i;
  logic     rst_ni;
  logic     cmd_valid_i;
  ctr_cmd_t cmd_i;
  logic     cmd_credit_o;
  logic     out_valid_o;
  ctr_rsp_t out_o;
  logic     out_credit_i = 1'b0;
  logic     alert_o;

  // Stimulus table
  string       tname [NumTests];
  ctr_cmd_t    tcmd  [NumTests];
  ctr_rsp_t    texp  [NumTests];
  int unsigned n_added;

  // Scoreboard, one queue of table rows per lane
  int unsigned exp_q [`CTR_LANES][$];
  int unsigned ret_due [$];

  int unsigned host_credits = `CTR_CMD_CREDITS;
  int unsigned credits_back;
  int unsigned results;
  int unsigned errors;
  int unsigned cycle;
  logic        hold_credits = 1'b0;

  ctr_top i_ctr_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .cmd_credit_o (cmd_credit_o),
    .out_valid_o  (out_valid_o),
    .out_o        (out_o),
    .out_credit_i (out_credit_i),
    .alert_o      (alert_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_rsp(input string name, input ctr_rsp_t exp, input ctr_rsp_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected lane %0d value %h, actual lane %0d value %h",
               name, exp.lane, exp.value, act.lane, act.value);
      errors++;
    end else begin
      $display("ok %s: lane %0d value %h", name, act.lane, act.value);
    end
  endtask

  task automatic check_alert(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected alert %b, actual alert %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int unsigned exp, input int unsigned act);
    if (act != exp) begin
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end else begin
      $display("ok %s: %0d", name, act);
    end
  endtask

  ////////////////////
  // Table and host
  ////////////////////

  task automatic add_test(input string name, input lane_idx_t l, input ctr_op_e op,
                          input ctr_value_t value, input ctr_value_t exp_value);
    tname[n_added] = name;
    tcmd[n_added]  = '{lane: l, op: op, value: value};
    texp[n_added]  = '{lane: l, value: exp_value};
    n_added++;
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic send_cmd(input int unsigned idx);
    while (host_credits == 0) begin
      @(posedge clk_i);
      #1;
    end
    cmd_valid_i = 1'b1;
    cmd_i       = tcmd[idx];
    host_credits--;
    exp_q[tcmd[idx].lane].push_back(idx);
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b0;
  endtask

  ////////////////////
  // Output side
  ////////////////////

  // Sampled mid-cycle where everything is settled
  always @(negedge clk_i) begin
    int unsigned row;

    if (rst_ni) begin
      if (cmd_credit_o) begin
        host_credits++;
        credits_back++;
      end
      if (out_valid_o) begin
        if (exp_q[out_o.lane].size() == 0) begin
          $display("Error: unexpected result from lane %0d", out_o.lane);
          errors++;
        end else begin
          row = exp_q[out_o.lane].pop_front();
          check_rsp(tname[row], texp[row], out_o);
        end
        check_alert("alert during traffic", 1'b0, alert_o);
        results++;
        ret_due.push_back(cycle + ($urandom % 4) + 1);
      end
    end
  end

  // Consumer, one credit back per cycle at most
  always @(posedge clk_i) begin
    cycle++;
    #1;
    if (!hold_credits && (ret_due.size() > 0) && (ret_due[0] <= cycle)) begin
      void'(ret_due.pop_front());
      out_credit_i = 1'b1;
    end else begin
      out_credit_i = 1'b0;
    end
  end

  // Back-pressure stretch early in the run
  initial begin
    @(posedge rst_ni);
    repeat (6) @(posedge clk_i);
    hold_credits = 1'b1;
    repeat (50) @(posedge clk_i);
    hold_credits = 1'b0;
  end

  initial begin
    repeat (16 + 40 * NumTests) @(posedge clk_i);
    $display("Error: watchdog timeout with %0d of %0d results received", results, NumTests);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(1));
    rst_ni      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;

    // Loads, then carries inside a slice, across one and several slices, and the wrap
    add_test("load_l0", 2'd0, CTR_OP_LOAD, 128'h0123_4567_89ab_cdef_0011_2233_4455_6677,
             128'h0123_4567_89ab_cdef_0011_2233_4455_6677);
    add_test("load_l1", 2'd1, CTR_OP_LOAD, '1, '1);
    add_test("load_l2", 2'd2, CTR_OP_LOAD, 128'h0000_0000_0000_0000_0000_ffff_ffff_ffff,
             128'h0000_0000_0000_0000_0000_ffff_ffff_ffff);
    add_test("load_l3", 2'd3, CTR_OP_LOAD, 128'h0000_ffff, 128'h0000_ffff);
    add_test("incr_l0_plain", 2'd0, CTR_OP_INCR, '0,
             128'h0123_4567_89ab_cdef_0011_2233_4455_6678);
    add_test("incr_l1_wrap", 2'd1, CTR_OP_INCR, '0, '0);
    add_test("incr_l2_multi", 2'd2, CTR_OP_INCR, '0,
             128'h0000_0000_0000_0000_0001_0000_0000_0000);
    add_test("incr_l3_one_slice", 2'd3, CTR_OP_INCR, '0, 128'h0001_0000);
    add_test("incr_l1_after_wrap", 2'd1, CTR_OP_INCR, '0, 128'h1);
    add_test("incr_l0_again", 2'd0, CTR_OP_INCR, '0,
             128'h0123_4567_89ab_cdef_0011_2233_4455_6679);
    add_test("load_l3_top", 2'd3, CTR_OP_LOAD, {1'b0, {127{1'b1}}}, {1'b0, {127{1'b1}}});
    add_test("incr_l3_top", 2'd3, CTR_OP_INCR, '0, {1'b1, 127'h0});
    add_test("load_l2_again", 2'd2, CTR_OP_LOAD, 128'hdead_beef_cafe_f00d_1234_5678_9abc_def0,
             128'hdead_beef_cafe_f00d_1234_5678_9abc_def0);
    add_test("incr_l2_again", 2'd2, CTR_OP_INCR, '0,
             128'hdead_beef_cafe_f00d_1234_5678_9abc_def1);

    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_alert("alert after reset", 1'b0, alert_o);

    for (int unsigned i = 0; i < NumTests; i++) begin
      send_cmd(i);
    end

    while (results < NumTests) begin
      @(posedge clk_i);
    end
    // Let the last lane credits flow back
    repeat (4) @(posedge clk_i);

    check_count("host credits returned", NumTests, credits_back);
    check_alert("alert at end", 1'b0, alert_o);

    $display("Results: %0d of %0d received, %0d errors", results, NumTests, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+hw
hw/ctr_pkg.sv
hw/ctr_dispatch.sv
hw/ctr_lane.sv
hw/ctr_collect.sv
hw/ctr_top.sv
sim/ctr_asserts.sv
sim/ctr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the counter-block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f vlog.f --top-module ctr_tb -o Vctr_tb

./obj_dir/Vctr_tb 2>&1 | tee sim.log

# Verdict comes from the log
if grep -qx "Simulation completed successfully" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
